// File: tb.f
awg_pkg.sv
awg_regs_pkg.sv
awg_if.sv
awg_regs.sv
awg_loader.sv
awg_buffer.sv
awg_player.sv
awg_top.sv
tb_awg.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_awg
LOG ?= sim.log
FLAGS ?= --binary --timing -j 0
OBJ_DIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f tb.f

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_awg.sv
`timescale 1ns/10ps

module tb_awg;
  import awg_pkg::*;
  import awg_regs_pkg::*;

  localparam int CHANNELS = 2;
  localparam int DEPTH = 16;
  localparam int NUM_ROWS = 5;
  // cycles allowed for one handshake or state change
  localparam int WAIT_LIMIT = 50;
  // cycles allowed for a whole burst to come out
  localparam int PLAY_LIMIT = 4000;

  // one test case with channel 0 in the low fields
  typedef struct {
    logic [CHANNELS-1:0][3:0] last;
    logic [CHANNELS-1:0][1:0] trig;
    logic [CHANNELS-1:0][15:0] burst;
    int nwords;
    bit with_last;
    logic [1:0] code;
    bit stop_mid;
  } row_t;

  logic dac_clk;
  logic dma_reset;
  logic [AXIL_ADDR_WIDTH-1:0] s_axil_awaddr;
  logic s_axil_awvalid;
  logic s_axil_awready;
  logic [31:0] s_axil_wdata;
  logic s_axil_wvalid;
  logic s_axil_wready;
  logic [1:0] s_axil_bresp;
  logic s_axil_bvalid;
  logic s_axil_bready;
  logic [AXIL_ADDR_WIDTH-1:0] s_axil_araddr;
  logic s_axil_arvalid;
  logic s_axil_arready;
  logic [31:0] s_axil_rdata;
  logic [1:0] s_axil_rresp;
  logic s_axil_rvalid;
  logic s_axil_rready;
  logic [31:0] s_data;
  logic s_valid;
  logic s_ready;
  logic s_last;
  logic [CHANNELS-1:0][31:0] dac_data;
  logic dac_valid;
  logic [CHANNELS-1:0] dac_trigger;

  row_t rows[NUM_ROWS];
  // stream words of the current load with channel 0 first
  logic [31:0] sent[2*DEPTH];
  int errors;
  int checks;

  awg_top #(.CHANNELS(CHANNELS), .DEPTH(DEPTH)) i_dut (.*);

  initial dac_clk = 1'b0;
  always #50 dac_clk = ~dac_clk;

  //////////////////////////////
  // reporting
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  //////////////////////////////
  // AXI4-Lite master
  //////////////////////////////

  task automatic axil_write(input logic [AXIL_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int timer;
    logic taken;
    @(negedge dac_clk);
    s_axil_awaddr = addr;
    s_axil_wdata = data;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid = 1'b1;
    resp = 2'b11;
    timer = 0;
    taken = 1'b0;
    // the ready pair is sampled just before the edge that takes the write
    while (!taken && timer < WAIT_LIMIT) begin
      @(posedge dac_clk);
      taken = s_axil_awready & s_axil_wready;
      timer++;
    end
    @(negedge dac_clk);
    s_axil_awvalid = 1'b0;
    s_axil_wvalid = 1'b0;
    if (taken) begin
      // response is due one cycle after the write was taken
      check_value("s_axil_bvalid", 32'd1, 32'(s_axil_bvalid));
      resp = s_axil_bresp;
    end else begin
      report_problem("awready and wready never rose together for the write");
    end
  endtask

  task automatic axil_read(input logic [AXIL_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int timer;
    logic taken;
    @(negedge dac_clk);
    s_axil_araddr = addr;
    s_axil_arvalid = 1'b1;
    data = '1;
    resp = 2'b11;
    timer = 0;
    taken = 1'b0;
    while (!taken && timer < WAIT_LIMIT) begin
      @(posedge dac_clk);
      taken = s_axil_arready;
      timer++;
    end
    @(negedge dac_clk);
    s_axil_arvalid = 1'b0;
    if (taken) begin
      // read data is due one cycle after the address was taken
      check_value("s_axil_rvalid", 32'd1, 32'(s_axil_rvalid));
      data = s_axil_rdata;
      resp = s_axil_rresp;
    end else begin
      report_problem("arready never rose for the read");
    end
  endtask

  task automatic write_expect(input logic [AXIL_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp, input string name);
    logic [1:0] resp;
    axil_write(addr, data, resp);
    check_value(name, 32'(exp_resp), 32'(resp));
  endtask

  task automatic read_expect(input logic [AXIL_ADDR_WIDTH-1:0] addr,
                             input logic [31:0] expected, input string name);
    logic [31:0] data;
    logic [1:0] resp;
    axil_read(addr, data, resp);
    check_value({name, " rresp"}, 32'(RESP_OKAY), 32'(resp));
    check_value(name, expected, data);
  endtask

  //////////////////////////////
  // stream and status helpers
  //////////////////////////////

  task automatic wait_for_ready(input logic level);
    int timer;
    timer = 0;
    while (s_ready !== level && timer < WAIT_LIMIT) begin
      @(negedge dac_clk);
      timer++;
    end
    if (s_ready !== level) begin
      report_problem($sformatf("s_ready never went to %0b", level));
    end
  endtask

  // polls the state field until the loader is back in idle
  task automatic wait_loader_idle();
    logic [31:0] status;
    logic [1:0] resp;
    int tries;
    tries = 0;
    status = '1;
    while (status[4:3] != 2'd0 && tries < WAIT_LIMIT) begin
      axil_read(ADDR_STATUS, status, resp);
      tries++;
    end
    check_value("status state", 32'(LOAD_IDLE), 32'(status[4:3]));
  endtask

  // bit 0 forced so a loaded word never looks like the idle zero
  task automatic fill_words();
    for (int i = 0; i < 2 * DEPTH; i++) begin
      sent[i] = $urandom | 32'h1;
    end
  endtask

  // a word goes out whenever s_ready was high at the falling edge
  task automatic send_stream(input int n, input bit with_last);
    int idx;
    int timer;
    idx = 0;
    timer = 0;
    while (idx < n && timer < 4 * WAIT_LIMIT) begin
      @(negedge dac_clk);
      timer++;
      if (s_ready) begin
        s_data = sent[idx];
        s_valid = 1'b1;
        s_last = with_last && (idx == n - 1);
        idx++;
      end else begin
        s_valid = 1'b0;
        s_last = 1'b0;
      end
    end
    @(negedge dac_clk);
    s_valid = 1'b0;
    s_last = 1'b0;
    if (idx < n) begin
      report_problem("loader did not take every stream word");
    end
  endtask

  // bus word of one register with fields packed per channel
  function automatic logic [31:0] field_word(input row_t r,
                                             input logic [AXIL_ADDR_WIDTH-1:0] addr);
    logic [31:0] w;
    w = '0;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      case (addr)
        ADDR_DEPTH: w[ch*4 +: 4] = r.last[ch];
        ADDR_TRIG: w[ch*2 +: 2] = r.trig[ch];
        default: w[ch*16 +: 16] = r.burst[ch];
      endcase
    end
    return w;
  endfunction

  function automatic row_t make_row(input int last0, input int last1, input int trig0,
                                    input int trig1, input int burst0, input int burst1,
                                    input int nwords, input bit with_last, input int code,
                                    input bit stop_mid);
    row_t r;
    r.last = {4'(last1), 4'(last0)};
    r.trig = {2'(trig1), 2'(trig0)};
    r.burst = {16'(burst1), 16'(burst0)};
    r.nwords = nwords;
    r.with_last = with_last;
    r.code = 2'(code);
    r.stop_mid = stop_mid;
    return r;
  endfunction

  //////////////////////////////
  // playback checks
  //////////////////////////////

  task automatic play_and_check(input row_t r);
    int frames[CHANNELS];
    int len[CHANNELS];
    int offs[CHANNELS];
    int count[CHANNELS];
    int trigs[CHANNELS];
    int exp_trigs;
    int timer;
    int tail;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      // burst 0 still plays one frame
      frames[ch] = (r.burst[ch] == 16'd0) ? 1 : int'(r.burst[ch]);
      len[ch] = int'(r.last[ch]) + 1;
      offs[ch] = (ch == 0) ? 0 : offs[ch-1] + len[ch-1];
      count[ch] = 0;
      trigs[ch] = 0;
    end
    write_expect(ADDR_CTRL, 32'h1, RESP_OKAY, "bresp start");
    timer = 0;
    tail = 0;
    // run until every channel is through, then watch a few idle cycles
    while (tail < 10 && timer < PLAY_LIMIT) begin
      @(negedge dac_clk);
      timer++;
      for (int ch = 0; ch < CHANNELS; ch++) begin
        if (dac_trigger[ch]) begin
          trigs[ch]++;
          check_value($sformatf("trigger %0d word index", ch), 32'd0,
                      32'(count[ch] % len[ch]));
          check_value($sformatf("dac_data[%0d] at trigger", ch), sent[offs[ch]], dac_data[ch]);
        end
        if (dac_data[ch] != 32'd0) begin
          if (count[ch] < len[ch] * frames[ch]) begin
            check_value($sformatf("dac_data[%0d]", ch), sent[offs[ch] + count[ch] % len[ch]],
                        dac_data[ch]);
          end else begin
            report_problem($sformatf("dac_data[%0d] not zero after the burst", ch));
          end
          count[ch]++;
        end else if (count[ch] > 0 && count[ch] < len[ch] * frames[ch]) begin
          report_problem($sformatf("gap in the dac_data[%0d] sequence", ch));
        end
      end
      if (count[0] >= len[0] * frames[0] && count[1] >= len[1] * frames[1]) begin
        tail++;
      end
    end
    if (timer >= PLAY_LIMIT) begin
      report_problem("burst did not finish in time");
    end
    for (int ch = 0; ch < CHANNELS; ch++) begin
      if (r.trig[ch] == 2'd2) begin
        exp_trigs = frames[ch];
      end else if (r.trig[ch] == 2'd1) begin
        exp_trigs = 1;
      end else begin
        exp_trigs = 0;
      end
      check_value($sformatf("trigger count %0d", ch), 32'(exp_trigs), 32'(trigs[ch]));
    end
    // play_done sends the loader back to idle
    wait_loader_idle();
  endtask

  task automatic stop_mid_burst(input row_t r);
    int timer;
    write_expect(ADDR_CTRL, 32'h1, RESP_OKAY, "bresp start");
    timer = 0;
    while (dac_data[0] == 32'd0 && timer < WAIT_LIMIT) begin
      @(negedge dac_clk);
      timer++;
    end
    if (dac_data[0] == 32'd0) begin
      report_problem("playback never started before the stop");
    end
    write_expect(ADDR_CTRL, 32'h2, RESP_OKAY, "bresp stop");
    timer = 0;
    while (dac_data != '0 && timer < WAIT_LIMIT) begin
      @(negedge dac_clk);
      timer++;
    end
    // output must stay quiet once the player is idle
    for (int n = 0; n < 10; n++) begin
      @(negedge dac_clk);
      for (int ch = 0; ch < CHANNELS; ch++) begin
        check_value($sformatf("dac_data[%0d] after stop", ch), 32'd0, dac_data[ch]);
      end
      check_value("dac_trigger after stop", 32'd0, 32'(dac_trigger));
    end
    wait_loader_idle();
    write_expect(ADDR_DEPTH, field_word(r, ADDR_DEPTH), RESP_OKAY, "bresp depth after stop");
    // finish that new load and release it again
    wait_for_ready(1'b1);
    fill_words();
    send_stream(int'(r.last[0]) + int'(r.last[1]) + 2, 1'b1);
    wait_for_ready(1'b0);
    write_expect(ADDR_CTRL, 32'h2, RESP_OKAY, "bresp stop after reload");
    wait_loader_idle();
  endtask

  //////////////////////////////
  // one table row
  //////////////////////////////

  task automatic run_row(input int idx);
    row_t r;
    logic [31:0] status;
    logic [1:0] resp;
    int errors_before;
    r = rows[idx];
    errors_before = errors;
    check_value("s_ready before arm", 32'd0, 32'(s_ready));
    write_expect(ADDR_TRIG, field_word(r, ADDR_TRIG), RESP_OKAY, "bresp trig");
    write_expect(ADDR_BURST, field_word(r, ADDR_BURST), RESP_OKAY, "bresp burst");
    write_expect(ADDR_DEPTH, field_word(r, ADDR_DEPTH), RESP_OKAY, "bresp depth");
    wait_for_ready(1'b1);
    // loader busy, so this depth must be refused and not stored
    write_expect(ADDR_DEPTH, 32'h0, RESP_SLVERR, "bresp depth while accepting");
    read_expect(ADDR_DEPTH, field_word(r, ADDR_DEPTH), "depth readback");
    read_expect(ADDR_TRIG, field_word(r, ADDR_TRIG), "trig readback");
    read_expect(ADDR_BURST, field_word(r, ADDR_BURST), "burst readback");
    fill_words();
    send_stream(r.nwords, r.with_last);
    wait_for_ready(1'b0);
    axil_read(ADDR_STATUS, status, resp);
    check_value("status code", 32'(r.code), 32'(status[1:0]));
    check_value("status valid", 32'd1, 32'(status[2]));
    check_value("status state", 32'(LOAD_BLOCKING), 32'(status[4:3]));
    // valid bit clears once read
    axil_read(ADDR_STATUS, status, resp);
    check_value("status valid after read", 32'd0, 32'(status[2]));
    if (r.code == 2'd2) begin
      // a partly written buffer is not played
      write_expect(ADDR_CTRL, 32'h2, RESP_OKAY, "bresp stop");
      wait_loader_idle();
    end else if (r.stop_mid) begin
      stop_mid_burst(r);
    end else begin
      play_and_check(r);
    end
    $display("test %0d finished with %0d errors", idx, errors - errors_before);
  endtask

  initial begin
    int timer;
    void'($urandom(32'h61d7_7eae));
    errors = 0;
    checks = 0;
    dma_reset = 1'b1;
    s_axil_awaddr = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata = '0;
    s_axil_wvalid = 1'b0;
    s_axil_bready = 1'b1;
    s_axil_araddr = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready = 1'b1;
    s_data = '0;
    s_valid = 1'b0;
    s_last = 1'b0;
    // last0 last1 trig0 trig1 burst0 burst1 words last code stop
    rows[0] = make_row(3, 5, 1, 2, 2, 3, 10, 1'b1, 0, 1'b0);
    rows[1] = make_row(7, 2, 2, 0, 0, 1, 11, 1'b0, 1, 1'b0);
    rows[2] = make_row(4, 4, 0, 1, 1, 1, 4, 1'b1, 2, 1'b0);
    rows[3] = make_row(15, 0, 2, 2, 1, 4, 17, 1'b1, 0, 1'b0);
    rows[4] = make_row(5, 6, 2, 1, 200, 200, 13, 1'b1, 0, 1'b1);
    @(posedge dac_clk);
    @(negedge dac_clk);
    // everything quiet while reset is held
    check_value("dac_valid in reset", 32'd0, 32'(dac_valid));
    check_value("s_ready in reset", 32'd0, 32'(s_ready));
    check_value("bvalid in reset", 32'd0, 32'(s_axil_bvalid));
    check_value("rvalid in reset", 32'd0, 32'(s_axil_rvalid));
    check_value("dac_trigger in reset", 32'd0, 32'(dac_trigger));
    check_value("dac_data in reset", 32'd0, dac_data[0] | dac_data[1]);
    @(posedge dac_clk);
    @(negedge dac_clk);
    dma_reset = 1'b0;
    timer = 0;
    while (!dac_valid && timer < WAIT_LIMIT) begin
      @(negedge dac_clk);
      timer++;
    end
    check_value("dac_valid rise cycle", 32'd3, 32'(timer));
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    check_value("dac_valid at end", 32'd1, 32'(dac_valid));
    $display("%0d tests, %0d checks, %0d errors", NUM_ROWS, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: awg_top.sv
`timescale 1ns/10ps

module awg_top #(
  parameter int CHANNELS = 2,
  parameter int DEPTH = 16
) (
  input  logic dac_clk,
  input  logic dma_reset,
  // AXI4-Lite slave
  input  logic [awg_regs_pkg::AXIL_ADDR_WIDTH-1:0] s_axil_awaddr,
  input  logic s_axil_awvalid,
  output logic s_axil_awready,
  input  logic [31:0] s_axil_wdata,
  input  logic s_axil_wvalid,
  output logic s_axil_wready,
  output logic [1:0] s_axil_bresp,
  output logic s_axil_bvalid,
  input  logic s_axil_bready,
  input  logic [awg_regs_pkg::AXIL_ADDR_WIDTH-1:0] s_axil_araddr,
  input  logic s_axil_arvalid,
  output logic s_axil_arready,
  output logic [31:0] s_axil_rdata,
  output logic [1:0] s_axil_rresp,
  output logic s_axil_rvalid,
  input  logic s_axil_rready,
  // waveform stream
  input  awg_pkg::word_t s_data,
  input  logic s_valid,
  output logic s_ready,
  input  logic s_last,
  // dac side
  output awg_pkg::word_t [CHANNELS-1:0] dac_data,
  output logic dac_valid,
  output logic [CHANNELS-1:0] dac_trigger
);
  import awg_pkg::*;

  logic [CHANNELS-1:0][$clog2(DEPTH)-1:0] rd_addr;
  word_t [CHANNELS-1:0] rd_data;

  awg_cfg_if #(.CHANNELS(CHANNELS), .DEPTH(DEPTH)) cfg_if ();
  awg_wr_if #(.CHANNELS(CHANNELS), .DEPTH(DEPTH)) wr_if ();

  awg_regs #(.CHANNELS(CHANNELS), .DEPTH(DEPTH)) i_regs (
    .dac_clk, .dma_reset,
    .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
    .s_axil_wdata, .s_axil_wvalid, .s_axil_wready,
    .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
    .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
    .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
    .cfg(cfg_if.regs)
  );

  awg_loader #(.CHANNELS(CHANNELS), .DEPTH(DEPTH)) i_loader (
    .dac_clk, .dma_reset,
    .s_data, .s_valid, .s_last, .s_ready,
    .cfg(cfg_if.loader),
    .wr(wr_if.source)
  );

  awg_buffer #(.CHANNELS(CHANNELS), .DEPTH(DEPTH)) i_buffer (
    .dac_clk,
    .wr(wr_if.sink),
    .rd_addr,
    .rd_data
  );

  awg_player #(.CHANNELS(CHANNELS), .DEPTH(DEPTH)) i_player (
    .dac_clk, .dma_reset,
    .cfg(cfg_if.player),
    .rd_addr, .rd_data,
    .dac_data, .dac_valid, .dac_trigger
  );

endmodule

// File: awg_player.sv
`timescale 1ns/10ps

module awg_player #(
  parameter int CHANNELS = 2,
  parameter int DEPTH = 16,
  localparam int AW = $clog2(DEPTH)
) (
  input  logic dac_clk,
  input  logic dma_reset,
  awg_cfg_if.player cfg,
  output logic [CHANNELS-1:0][AW-1:0] rd_addr,
  input  awg_pkg::word_t [CHANNELS-1:0] rd_data,
  output awg_pkg::word_t [CHANNELS-1:0] dac_data,
  output logic dac_valid,
  output logic [CHANNELS-1:0] dac_trigger
);
  import awg_pkg::*;

  logic active;
  logic [CHANNELS-1:0][BURST_WIDTH-1:0] frame;
  logic [CHANNELS-1:0][BURST_WIDTH-1:0] last_frame;
  logic [CHANNELS-1:0] addr_at_max;
  logic [CHANNELS-1:0] frame_at_max;
  logic [CHANNELS-1:0] finished;
  logic [CHANNELS-1:0] trig_hit;
  // two stages to line up with the buffer read
  logic [1:0][CHANNELS-1:0] zero_pipe;
  logic [1:0][CHANNELS-1:0] trig_pipe;
  logic [2:0] valid_sr;

  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      // burst of 0 plays a single frame
      last_frame[ch] = (cfg.burst_len[ch] == '0) ? '0 : cfg.burst_len[ch] - 1'b1;
      addr_at_max[ch] = rd_addr[ch] == cfg.last_addr[ch];
      frame_at_max[ch] = frame[ch] == last_frame[ch];
      // trigger on word 0 of a frame still to be played
      trig_hit[ch] = active & ~finished[ch] & (rd_addr[ch] == '0) &
                     ((cfg.trig_mode[ch] == TRIG_EVERY) |
                      ((cfg.trig_mode[ch] == TRIG_FIRST) & (frame[ch] == '0)));
    end
  end

  //////////////////////////////
  // playback FSM and counters
  //////////////////////////////

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      active <= 1'b0;
    end else if (active) begin
      if (cfg.stop || cfg.play_done) active <= 1'b0;
    end else if (cfg.start) begin
      active <= 1'b1;
    end
  end

  always_ff @(posedge dac_clk) begin
    if (dma_reset || !active) begin
      // idle holds address 0 ready for the first active cycle
      rd_addr <= '0;
      frame <= '0;
      finished <= '0;
    end else begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        if (!finished[ch]) begin
          if (addr_at_max[ch]) begin
            rd_addr[ch] <= '0;
            frame[ch] <= frame[ch] + 1'b1;
            if (frame_at_max[ch]) finished[ch] <= 1'b1;
          end else begin
            rd_addr[ch] <= rd_addr[ch] + 1'b1;
          end
        end
      end
    end
  end

  // one pulse once every channel is through
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      cfg.play_done <= 1'b0;
    end else begin
      cfg.play_done <= active & (&finished) & ~cfg.play_done;
    end
  end

  //////////////////////////////
  // output stage
  //////////////////////////////

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      zero_pipe <= '1;
      trig_pipe <= '0;
      dac_trigger <= '0;
      dac_data <= '0;
      valid_sr <= '0;
    end else begin
      zero_pipe[0] <= {CHANNELS{~active}} | finished;
      zero_pipe[1] <= zero_pipe[0];
      trig_pipe[0] <= trig_hit;
      trig_pipe[1] <= trig_pipe[0];
      dac_trigger <= trig_pipe[1];
      valid_sr <= {valid_sr[1:0], 1'b1};
      for (int ch = 0; ch < CHANNELS; ch++) begin
        dac_data[ch] <= zero_pipe[1][ch] ? '0 : rd_data[ch];
      end
    end
  end

  // output runs freely once out of reset
  assign dac_valid = valid_sr[2];

endmodule

// File: awg_buffer.sv
`timescale 1ns/10ps

module awg_buffer #(
  parameter int CHANNELS = 2,
  parameter int DEPTH = 16,
  localparam int AW = $clog2(DEPTH),
  localparam int CW = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) (
  input  logic dac_clk,
  awg_wr_if.sink wr,
  input  logic [CHANNELS-1:0][AW-1:0] rd_addr,
  output awg_pkg::word_t [CHANNELS-1:0] rd_data
);
  import awg_pkg::*;

  // one memory per channel, all read in parallel
  for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_chan
    word_t mem [DEPTH];
    word_t rd_q;

    always_ff @(posedge dac_clk) begin
      if (wr.en && wr.channel == CW'(ch)) begin
        mem[wr.addr] <= wr.data;
      end
      // memory output register then one more stage
      rd_q <= mem[rd_addr[ch]];
      rd_data[ch] <= rd_q;
    end
  end

endmodule

// File: awg_loader.sv
`timescale 1ns/10ps

module awg_loader #(
  parameter int CHANNELS = 2,
  parameter int DEPTH = 16,
  localparam int AW = $clog2(DEPTH),
  localparam int CW = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) (
  input  logic dac_clk,
  input  logic dma_reset,
  input  awg_pkg::word_t s_data,
  input  logic s_valid,
  input  logic s_last,
  output logic s_ready,
  awg_cfg_if.loader cfg,
  awg_wr_if.source wr
);
  import awg_pkg::*;

  load_state_e state;
  word_t word_q;
  logic last_q;
  logic word_valid;
  logic [AW-1:0] wr_addr;
  logic [CW-1:0] wr_chan;
  // set once a channel has taken its last address
  logic [CHANNELS-1:0] chan_full;
  logic accept;
  logic addr_at_max;
  logic last_chan;
  logic buffer_end;

  assign s_ready = state == LOAD_ACCEPTING;
  assign accept = s_valid & s_ready;

  // accepted word is written one cycle later
  assign wr.en = word_valid & ~chan_full[wr_chan];
  assign wr.channel = wr_chan;
  assign wr.addr = wr_addr;
  assign wr.data = word_q;

  assign addr_at_max = wr_addr == cfg.last_addr[wr_chan];
  assign last_chan = wr_chan == CW'(CHANNELS - 1);
  assign buffer_end = wr.en & addr_at_max & last_chan;

  // status report on the final write or on an early last
  // code 0 for a clean load, 1 when last never came, 2 when it came early
  assign cfg.err_set = buffer_end | (wr.en & last_q);
  assign cfg.err_code = buffer_end ? {1'b0, ~last_q} : 2'd2;
  assign cfg.load_state = state;

  //////////////////////////////
  // loader FSM
  //////////////////////////////

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      state <= LOAD_IDLE;
    end else begin
      case (state)
        LOAD_IDLE: if (cfg.arm) state <= LOAD_ACCEPTING;
        // ends on last or on the final buffer address
        LOAD_ACCEPTING: if ((accept && s_last) || buffer_end) state <= LOAD_BLOCKING;
        LOAD_BLOCKING: if (cfg.stop || cfg.play_done) state <= LOAD_IDLE;
        default: state <= LOAD_IDLE;
      endcase
    end
  end

  // stream word staging
  always_ff @(posedge dac_clk) begin
    word_q <= s_data;
    last_q <= s_last;
  end

  // write pointer walks each channel up to its last address
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      word_valid <= 1'b0;
      wr_addr <= '0;
      wr_chan <= '0;
      chan_full <= '0;
    end else begin
      word_valid <= accept;
      if (state == LOAD_IDLE) begin
        wr_addr <= '0;
        wr_chan <= '0;
        chan_full <= '0;
      end else if (wr.en) begin
        if (addr_at_max) begin
          wr_addr <= '0;
          chan_full[wr_chan] <= 1'b1;
          // wrap keeps extra words off channel 0 since it is already full
          wr_chan <= last_chan ? '0 : wr_chan + 1'b1;
        end else begin
          wr_addr <= wr_addr + 1'b1;
        end
      end
    end
  end

endmodule

// File: awg_regs.sv
`timescale 1ns/10ps

module awg_regs #(
  parameter int CHANNELS = 2,
  parameter int DEPTH = 16,
  localparam int AW = $clog2(DEPTH)
) (
  input  logic dac_clk,
  input  logic dma_reset,
  input  logic [awg_regs_pkg::AXIL_ADDR_WIDTH-1:0] s_axil_awaddr,
  input  logic s_axil_awvalid,
  output logic s_axil_awready,
  input  logic [31:0] s_axil_wdata,
  input  logic s_axil_wvalid,
  output logic s_axil_wready,
  output logic [1:0] s_axil_bresp,
  output logic s_axil_bvalid,
  input  logic s_axil_bready,
  input  logic [awg_regs_pkg::AXIL_ADDR_WIDTH-1:0] s_axil_araddr,
  input  logic s_axil_arvalid,
  output logic s_axil_arready,
  output logic [31:0] s_axil_rdata,
  output logic [1:0] s_axil_rresp,
  output logic s_axil_rvalid,
  input  logic s_axil_rready,
  awg_cfg_if.regs cfg
);
  import awg_pkg::*;
  import awg_regs_pkg::*;

  reg_word_u wr_word;
  reg_word_u rd_word;
  logic [1:0] rd_resp;
  logic wr_accept;
  logic rd_accept;
  logic cfg_addr;
  logic cfg_locked;
  logic [1:0] err_code_q;
  logic err_valid;

  // address and data are taken together, one write in flight
  assign wr_accept = s_axil_awvalid & s_axil_wvalid & ~s_axil_bvalid;
  assign rd_accept = s_axil_arvalid & ~s_axil_rvalid;
  assign s_axil_awready = wr_accept;
  assign s_axil_wready = wr_accept;
  assign s_axil_arready = rd_accept;
  assign wr_word = s_axil_wdata;

  // configuration only changes while the loader is idle
  assign cfg_addr = s_axil_awaddr inside {ADDR_DEPTH, ADDR_TRIG, ADDR_BURST};
  assign cfg_locked = cfg.load_state != LOAD_IDLE;

  //////////////////////////////
  // write channel
  //////////////////////////////

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      cfg.last_addr <= '0;
      cfg.burst_len <= '0;
      for (int ch = 0; ch < CHANNELS; ch++) begin
        cfg.trig_mode[ch] <= TRIG_NONE;
      end
      cfg.arm <= 1'b0;
      cfg.start <= 1'b0;
      cfg.stop <= 1'b0;
      s_axil_bvalid <= 1'b0;
      s_axil_bresp <= RESP_OKAY;
    end else begin
      // commands are single cycle pulses
      cfg.arm <= 1'b0;
      cfg.start <= 1'b0;
      cfg.stop <= 1'b0;
      if (s_axil_bvalid && s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end
      if (wr_accept) begin
        s_axil_bvalid <= 1'b1;
        // locked config writes and unmapped or read-only words get slverr
        if ((cfg_addr && cfg_locked) || !(cfg_addr || s_axil_awaddr == ADDR_CTRL)) begin
          s_axil_bresp <= RESP_SLVERR;
        end else begin
          s_axil_bresp <= RESP_OKAY;
        end
        case (s_axil_awaddr)
          ADDR_CTRL: begin
            // no start while the buffers are being filled
            cfg.start <= wr_word.ctrl.start & (cfg.load_state != LOAD_ACCEPTING);
            cfg.stop <= wr_word.ctrl.stop;
          end
          ADDR_DEPTH: begin
            if (!cfg_locked) begin
              for (int ch = 0; ch < CHANNELS; ch++) begin
                cfg.last_addr[ch] <= AW'(wr_word.depth[ch]);
              end
              // depth write arms the loader
              cfg.arm <= 1'b1;
            end
          end
          ADDR_TRIG: begin
            if (!cfg_locked) begin
              for (int ch = 0; ch < CHANNELS; ch++) begin
                cfg.trig_mode[ch] <= trig_mode_e'(wr_word.trig[ch]);
              end
            end
          end
          ADDR_BURST: begin
            // a burst of 0 is kept, the player treats it as 1
            if (!cfg_locked) begin
              for (int ch = 0; ch < CHANNELS; ch++) begin
                cfg.burst_len[ch] <= wr_word.burst[ch];
              end
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  //////////////////////////////
  // load status
  //////////////////////////////

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      err_code_q <= 2'd0;
      err_valid <= 1'b0;
    end else if (cfg.arm) begin
      // new load starts with a clean status
      err_code_q <= 2'd0;
      err_valid <= 1'b0;
    end else if (cfg.err_set) begin
      err_code_q <= cfg.err_code;
      err_valid <= 1'b1;
    end else if (rd_accept && s_axil_araddr == ADDR_STATUS) begin
      // clear on read
      err_valid <= 1'b0;
    end
  end

  //////////////////////////////
  // read channel
  //////////////////////////////

  always_comb begin
    rd_word = '0;
    rd_resp = RESP_OKAY;
    case (s_axil_araddr)
      ADDR_CTRL: begin
        // commands read back as zero
        rd_word = '0;
      end
      ADDR_DEPTH: begin
        for (int ch = 0; ch < CHANNELS; ch++) begin
          rd_word.depth[ch] = 4'(cfg.last_addr[ch]);
        end
      end
      ADDR_TRIG: begin
        for (int ch = 0; ch < CHANNELS; ch++) begin
          rd_word.trig[ch] = cfg.trig_mode[ch];
        end
      end
      ADDR_BURST: begin
        for (int ch = 0; ch < CHANNELS; ch++) begin
          rd_word.burst[ch] = cfg.burst_len[ch];
        end
      end
      ADDR_STATUS: begin
        rd_word.status.code = err_code_q;
        rd_word.status.valid = err_valid;
        rd_word.status.state = cfg.load_state;
      end
      default: rd_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge dac_clk) begin
    if (rd_accept) begin
      s_axil_rdata <= rd_word;
      s_axil_rresp <= rd_resp;
    end
    if (dma_reset) begin
      s_axil_rvalid <= 1'b0;
    end else if (rd_accept) begin
      s_axil_rvalid <= 1'b1;
    end else if (s_axil_rready) begin
      s_axil_rvalid <= 1'b0;
    end
  end

endmodule

// File: awg_if.sv
`timescale 1ns/10ps

// configuration from the register block to loader and player
interface awg_cfg_if #(
  parameter int CHANNELS = 2,
  parameter int DEPTH = 16,
  localparam int AW = $clog2(DEPTH)
) ();
  import awg_pkg::*;

  logic [CHANNELS-1:0][AW-1:0] last_addr;
  trig_mode_e [CHANNELS-1:0] trig_mode;
  logic [CHANNELS-1:0][BURST_WIDTH-1:0] burst_len;
  // single cycle commands
  logic arm;
  logic start;
  logic stop;
  // loader status back to the register block
  load_state_e load_state;
  logic [1:0] err_code;
  logic err_set;
  // end of burst from the player
  logic play_done;

  modport regs (
    output last_addr, trig_mode, burst_len, arm, start, stop,
    input  load_state, err_code, err_set
  );
  modport loader (
    input  last_addr, arm, stop, play_done,
    output load_state, err_code, err_set
  );
  modport player (
    input  last_addr, trig_mode, burst_len, start, stop,
    output play_done
  );
endinterface

// buffer write port, loader to buffer
interface awg_wr_if #(
  parameter int CHANNELS = 2,
  parameter int DEPTH = 16,
  localparam int AW = $clog2(DEPTH),
  localparam int CW = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) ();
  import awg_pkg::*;

  logic en;
  logic [CW-1:0] channel;
  logic [AW-1:0] addr;
  word_t data;

  modport source (output en, channel, addr, data);
  modport sink (input en, channel, addr, data);
endinterface

// File: awg_regs_pkg.sv
package awg_regs_pkg;

  // byte addressed register space, five words
  localparam int AXIL_ADDR_WIDTH = 5;

  localparam logic [AXIL_ADDR_WIDTH-1:0] ADDR_CTRL   = 5'h00;
  localparam logic [AXIL_ADDR_WIDTH-1:0] ADDR_DEPTH  = 5'h04;
  localparam logic [AXIL_ADDR_WIDTH-1:0] ADDR_TRIG   = 5'h08;
  localparam logic [AXIL_ADDR_WIDTH-1:0] ADDR_BURST  = 5'h0C;
  localparam logic [AXIL_ADDR_WIDTH-1:0] ADDR_STATUS = 5'h10;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  //////////////////////////////
  // views of one bus word
  //////////////////////////////

  // start in bit 0, stop in bit 1
  typedef struct packed {
    logic [29:0] rsvd;
    logic        stop;
    logic        start;
  } ctrl_view_t;

  // error code in 1:0, valid in 2, loader state in 4:3
  typedef struct packed {
    logic [26:0] rsvd;
    logic [1:0]  state;
    logic        valid;
    logic [1:0]  code;
  } status_view_t;

  typedef union packed {
    ctrl_view_t          ctrl;
    logic [7:0][3:0]     depth;
    logic [15:0][1:0]    trig;
    logic [1:0][15:0]    burst;
    status_view_t        status;
  } reg_word_u;

endpackage

// File: awg_pkg.sv
package awg_pkg;

  //////////////////////////////
  // datapath word format
  //////////////////////////////

  localparam int SAMPLE_WIDTH = 16;
  localparam int PARALLEL_SAMPLES = 2;

  // one signed dac sample
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // stream word and buffer word share one format
  // sample 0 sits in the low half
  typedef sample_t [PARALLEL_SAMPLES-1:0] word_t;

  //////////////////////////////
  // playback and loader control
  //////////////////////////////

  // frames per burst, 0 plays one frame
  localparam int BURST_WIDTH = 16;

  // per-channel trigger output behaviour
  typedef enum logic [1:0] {
    TRIG_NONE  = 2'd0,
    TRIG_FIRST = 2'd1,
    TRIG_EVERY = 2'd2
  } trig_mode_e;

  // loader FSM, also visible in the status register
  typedef enum logic [1:0] {
    LOAD_IDLE      = 2'd0,
    LOAD_ACCEPTING = 2'd1,
    LOAD_BLOCKING  = 2'd2
  } load_state_e;

endpackage
